/* execute_stage.f */
hw/rv_isa_pkg.sv
hw/ex_pipe_pkg.sv
hw/operand_select.sv
hw/int_alu.sv
hw/branch_resolve.sv
hw/mul_iterative.sv
hw/ex_result_stage.sv
hw/execute_stage.sv
+incdir+include
bench/execute_stage_tb.sv

/* bench/execute_stage_testdata.txt */
add_reg   00000100 00000005 00000007 00000000 01 0 0 04 0 0 00000000 00000000 0 0 0000000c 4 0 00000000
sub_mem_a 00000104 00000005 00000014 00000000 02 1 0 04 1 0 00000064 00000000 0 0 00000050 4 0 00000000
xor_wb_b  00000108 ff00ff00 00000000 00000000 03 2 0 04 0 2 00000000 0f0f0f0f 0 0 f00ff00f 4 0 00000000
or_imm    0000010c 000000f0 00000000 0000000f 04 3 0 44 0 0 00000000 00000000 0 0 000000ff 4 0 00000000
and_reg   00000110 f0f0f0f0 ffff0000 00000000 05 4 0 04 0 0 00000000 00000000 0 0 f0f00000 4 0 00000000
sll_imm   00000114 00000001 00000000 00000024 06 5 0 44 0 0 00000000 00000000 0 0 00000010 4 0 00000000
srl_reg   00000118 80000000 00000004 00000000 07 6 0 04 0 0 00000000 00000000 0 0 08000000 4 0 00000000
sra_reg   0000011c 80000000 00000004 00000000 08 7 0 04 0 0 00000000 00000000 0 0 f8000000 4 0 00000000
slt_reg   00000120 ffffffff 00000001 00000000 09 8 0 04 0 0 00000000 00000000 0 0 00000001 4 0 00000000
sltu_reg  00000124 ffffffff 00000001 00000000 0a 9 0 04 0 0 00000000 00000000 0 0 00000000 4 0 00000000
lui_imm   00000128 00000000 00000000 12345fff 0b a 0 44 0 0 00000000 00000000 0 0 12345000 4 0 00000000
auipc     00000200 00000000 00000000 00001000 0c 0 0 c4 0 0 00000000 00000000 0 0 00001200 4 0 00000000
store_w   00000204 00001000 deadbeef 00000008 00 0 2 41 0 0 00000000 00000000 0 0 00001008 1 0 00000000
load_w    00000208 00002000 00000000 00000004 0d 0 2 46 0 0 00000000 00000000 0 0 00002004 6 0 00000000
beq_take  00000300 00000005 00000005 00000040 00 1 0 20 0 0 00000000 00000000 0 0 00000000 0 1 00000340
beq_not   00000300 00000005 00000006 00000040 00 1 0 20 0 0 00000000 00000000 0 0 ffffffff 0 0 00000000
bne_take  00000300 00000005 00000006 00000040 00 1 1 20 0 0 00000000 00000000 0 0 ffffffff 0 1 00000340
blt_take  00000300 ffffffff 00000001 00000040 00 8 4 20 0 0 00000000 00000000 0 0 00000001 0 1 00000340
bge_not   00000300 ffffffff 00000001 00000040 00 8 5 20 0 0 00000000 00000000 0 0 00000001 0 0 00000000
bge_back  00000300 00000003 ffffffff fffffff0 00 8 5 20 0 0 00000000 00000000 0 0 00000000 0 1 000002f0
bltu_not  00000300 ffffffff 00000001 00000040 00 9 6 20 0 0 00000000 00000000 0 0 00000000 0 0 00000000
bgeu_take 00000300 ffffffff 00000001 00000040 00 9 7 20 0 0 00000000 00000000 0 0 00000000 0 1 00000340
jal       00000400 00000000 00000000 00000100 01 0 0 d4 0 0 00000000 00000000 0 0 00000404 4 1 00000500
jalr      00000400 00001001 00000000 00000020 01 0 0 54 0 0 00000000 00000000 0 0 00000404 4 1 00001020
mul_lo    00000500 fffffffd 00000007 00000000 0e 0 0 0c 0 0 00000000 00000000 0 0 ffffffeb c 0 00000000
mulh      00000504 80000000 80000000 00000000 0f 0 1 0c 0 0 00000000 00000000 0 0 40000000 c 0 00000000
mulhsu    00000508 ffffffff ffffffff 00000000 10 0 2 0c 0 0 00000000 00000000 0 0 ffffffff c 0 00000000
mulhu     0000050c ffffffff ffffffff 00000000 11 0 3 0c 0 0 00000000 00000000 0 0 fffffffe c 0 00000000
mul_stall 00000510 00000006 00000007 00000000 12 0 0 0c 0 0 00000000 00000000 28 0 0000002a c 0 00000000
alu_stall 00000514 00000001 00000002 00000000 13 0 0 04 0 0 00000000 00000000 3 0 00000003 4 0 00000000
flush_ld  00000518 00000010 00000000 00000004 14 0 2 46 0 0 00000000 00000000 0 1 00000014 0 0 00000000
mul_fwd   0000051c 0000abcd 00001234 00000000 15 0 0 0c 1 2 00000003 00000005 0 0 0000000f c 0 00000000

/* include/execute_stage_tb_checks.svh */
// Execute stage testbench compare tasks
// Typed checks for EX/MEM contents, redirect outputs and single-bit flags

`ifndef EXECUTE_STAGE_TB_CHECKS_SVH
`define EXECUTE_STAGE_TB_CHECKS_SVH

int error_count = 0;
int test_pass   = 0;
int test_fail   = 0;

// Whole EX/MEM register in one compare
task automatic check_ex_mem(input string name, input ex_mem_t exp_v, input ex_mem_t act_v);
    if (act_v !== exp_v) begin
        $display("MISMATCH t=%0t %0s exp=%h act=%h", $time, name, exp_v, act_v);
        $display("  result exp=%h act=%h store exp=%h act=%h",
                 exp_v.result, act_v.result, exp_v.store_data, act_v.store_data);
        error_count++;
    end
endtask

// Target only matters when fetch is redirected
task automatic check_redirect(
    input logic  exp_r,
    input logic  act_r,
    input addr_t exp_t,
    input addr_t act_t
);
    if (act_r !== exp_r) begin
        $display("MISMATCH t=%0t redirect_o exp=%b act=%b", $time, exp_r, act_r);
        error_count++;
    end
    if (exp_r && (act_t !== exp_t)) begin
        $display("MISMATCH t=%0t redirect_target_o exp=%h act=%h", $time, exp_t, act_t);
        error_count++;
    end
endtask

task automatic check_stall(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
        $display("MISMATCH t=%0t %0s exp=%b act=%b", $time, name, exp_v, act_v);
        error_count++;
    end
endtask

`endif

/* bench/execute_stage_tb.sv */
// Execute stage testbench
// Runs vectors from the data file, then a random multiply sweep

module execute_stage_tb;
    import rv_isa_pkg::*;
    import ex_pipe_pkg::*;

    `include "execute_stage_tb_checks.svh"

    localparam int TIMEOUT_CYCLES = MUL_STEPS + 8;

    logic     clk_i;
    logic     rst_ni;
    id_ex_t   id_ex_i;
    ex_mem_t  ex_mem_fwd_i;
    word_t    wb_data_i;
    fwd_sel_t fwd_a_sel_i;
    fwd_sel_t fwd_b_sel_i;
    logic     stall_m_i;
    logic     flush_e_i;
    logic     ex_stall_req_o;
    logic     redirect_o;
    addr_t    redirect_target_o;
    ex_mem_t  ex_mem_o;

    // Current vector and its expected results
    id_ex_t     vec_id;
    fwd_sel_t   vec_fa;
    fwd_sel_t   vec_fb;
    word_t      vec_mem;
    word_t      vec_wb;
    int         vec_nstall;
    logic       vec_flush;
    word_t      exp_result;
    logic [3:0] exp_flags;
    logic       exp_redir;
    addr_t      exp_target;
    integer     seed = 51;

    execute_stage dut0 (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .id_ex_i           (id_ex_i),
        .ex_mem_fwd_i      (ex_mem_fwd_i),
        .wb_data_i         (wb_data_i),
        .fwd_a_sel_i       (fwd_a_sel_i),
        .fwd_b_sel_i       (fwd_b_sel_i),
        .stall_m_i         (stall_m_i),
        .flush_e_i         (flush_e_i),
        .ex_stall_req_o    (ex_stall_req_o),
        .redirect_o        (redirect_o),
        .redirect_target_o (redirect_target_o),
        .ex_mem_o          (ex_mem_o)
    );

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    // ========================================================================
    // One instruction through the stage
    // ========================================================================
    task automatic run_vector(input string tname);
        ex_mem_t expected;
        ex_mem_t held;
        word_t   fwd_b_val;
        int      waited;
        int      errs_before;
        errs_before  = error_count;
        id_ex_i      = vec_id;
        fwd_a_sel_i  = vec_fa;
        fwd_b_sel_i  = vec_fb;
        ex_mem_fwd_i = '0;
        ex_mem_fwd_i.result = vec_mem;
        wb_data_i    = vec_wb;
        stall_m_i    = (vec_nstall != 0);
        flush_e_i    = vec_flush;
        #2;
        check_redirect(exp_redir, redirect_o, exp_target, redirect_target_o);
        check_stall("ex_stall_req_o", vec_id.ctrl.mult_en, ex_stall_req_o);
        // Memory stage stall freezes EX/MEM
        held = ex_mem_o;
        for (int i = 0; i < vec_nstall; i++) begin
            @(posedge clk_i);
            #1;
            check_ex_mem("ex_mem_o under stall", held, ex_mem_o);
        end
        stall_m_i = 1'b0;
        waited = 0;
        while (ex_stall_req_o === 1'b1 && waited < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            #1;
            waited++;
        end
        if (ex_stall_req_o !== 1'b0) begin
            $display("TIMEOUT t=%0t %0s: stall request still high after %0d cycles",
                     $time, tname, waited);
            error_count++;
        end
        @(posedge clk_i);
        #1;
        fwd_b_val = forwarded_value(vec_fb, vec_id.rs2_data, vec_mem, vec_wb);
        expected.result     = exp_result;
        expected.store_data = fwd_b_val;
        expected.rd_addr    = vec_id.rd_addr;
        expected.ctrl       = vec_id.ctrl;
        {expected.ctrl.mult_en, expected.ctrl.reg_write_en,
         expected.ctrl.mem_read_en, expected.ctrl.mem_write_en} = exp_flags;
        check_ex_mem("ex_mem_o", expected, ex_mem_o);
        if (error_count == errs_before) begin
            test_pass++;
            $display("PASS %0s", tname);
        end else begin
            test_fail++;
            $display("FAIL %0s", tname);
        end
    endtask

    // Operand the stage sees after forwarding
    function automatic word_t forwarded_value(
        input fwd_sel_t sel,
        input word_t    reg_val,
        input word_t    mem_val,
        input word_t    wb_val
    );
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    // Signedness of each operand follows funct3
    function automatic word_t mul_expect(input funct3_t f3, input word_t a, input word_t b);
        logic [63:0] ax;
        logic [63:0] bx;
        logic [63:0] p;
        ax = (f3 != MUL_HU) ? {{32{a[31]}}, a} : {32'b0, a};
        bx = (f3 == MUL_LO || f3 == MUL_H) ? {{32{b[31]}}, b} : {32'b0, b};
        p  = ax * bx;
        return (f3 == MUL_LO) ? p[31:0] : p[63:32];
    endfunction

    initial begin
        integer     fd;
        integer     n;
        string      tname;
        logic [31:0] f[18];
        rst_ni       = 1'b0;
        id_ex_i      = '0;
        ex_mem_fwd_i = '0;
        wb_data_i    = '0;
        fwd_a_sel_i  = FWD_REG;
        fwd_b_sel_i  = FWD_REG;
        stall_m_i    = 1'b0;
        flush_e_i    = 1'b0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        #1;
        check_stall("ex_stall_req_o", 1'b0, ex_stall_req_o);
        check_stall("ex_mem_o.ctrl.reg_write_en", 1'b0, ex_mem_o.ctrl.reg_write_en);
        check_stall("ex_mem_o.ctrl.mem_read_en", 1'b0, ex_mem_o.ctrl.mem_read_en);
        check_stall("ex_mem_o.ctrl.mem_write_en", 1'b0, ex_mem_o.ctrl.mem_write_en);
        check_stall("ex_mem_o.ctrl.mult_en", 1'b0, ex_mem_o.ctrl.mult_en);
        if (error_count == 0) begin
            test_pass++;
            $display("PASS reset");
        end else begin
            test_fail++;
            $display("FAIL reset");
        end
        @(posedge clk_i);
        #1;

        fd = $fopen("bench/execute_stage_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h\n",
                            tname, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                            f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
                if (n == 19) begin
                    vec_id              = '0;
                    vec_id.pc           = f[0];
                    vec_id.rs1_data     = f[1];
                    vec_id.rs2_data     = f[2];
                    vec_id.immediate    = f[3];
                    vec_id.rd_addr      = f[4][4:0];
                    vec_id.ctrl.alu_op  = alu_op_t'(f[5][3:0]);
                    vec_id.ctrl.funct3  = f[6][2:0];
                    {vec_id.ctrl.alu_a_pc, vec_id.ctrl.alu_b_imm, vec_id.ctrl.is_branch,
                     vec_id.ctrl.is_jump, vec_id.ctrl.mult_en, vec_id.ctrl.reg_write_en,
                     vec_id.ctrl.mem_read_en, vec_id.ctrl.mem_write_en} = f[7][7:0];
                    vec_fa     = fwd_sel_t'(f[8][1:0]);
                    vec_fb     = fwd_sel_t'(f[9][1:0]);
                    vec_mem    = f[10];
                    vec_wb     = f[11];
                    vec_nstall = f[12];
                    vec_flush  = f[13][0];
                    exp_result = f[14];
                    exp_flags  = f[15][3:0];
                    exp_redir  = f[16][0];
                    exp_target = f[17];
                    run_vector(tname);
                end else if (n > 0) begin
                    $display("Malformed line in the test data file");
                    error_count++;
                end
            end
            $fclose(fd);
        end

        // Random multiply sweep, forwarding sources rotate each step
        for (int k = 0; k < 12; k++) begin
            vec_id               = '0;
            vec_id.rs1_data      = $random(seed);
            vec_id.rs2_data      = $random(seed);
            vec_id.rd_addr       = 5'(k + 1);
            vec_id.ctrl.funct3   = funct3_t'(k % 4);
            vec_id.ctrl.mult_en  = 1'b1;
            vec_id.ctrl.reg_write_en = 1'b1;
            vec_fa     = fwd_sel_t'(k % 3);
            vec_fb     = fwd_sel_t'((k + 1) % 3);
            vec_mem    = $random(seed);
            vec_wb     = $random(seed);
            vec_nstall = 0;
            vec_flush  = 1'b0;
            exp_result = mul_expect(vec_id.ctrl.funct3,
                                    forwarded_value(vec_fa, vec_id.rs1_data, vec_mem, vec_wb),
                                    forwarded_value(vec_fb, vec_id.rs2_data, vec_mem, vec_wb));
            exp_flags  = 4'b1100;
            exp_redir  = 1'b0;
            exp_target = '0;
            run_vector($sformatf("rand_mul_%0d", k));
        end
        id_ex_i   = '0;
        flush_e_i = 1'b0;

        $display("Tests passed %0d, failed %0d, errors %0d", test_pass, test_fail, error_count);
        if (error_count == 0 && test_fail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* hw/execute_stage.sv */
// Execute stage of the five-stage RV32IM pipeline
// Operand forwarding, ALU, branch redirect, iterative multiply and EX/MEM register

module execute_stage (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    // From decode
    input  ex_pipe_pkg::id_ex_t   id_ex_i,
    // Forwarding sources
    input  ex_pipe_pkg::ex_mem_t  ex_mem_fwd_i,
    input  rv_isa_pkg::word_t     wb_data_i,
    // Hazard unit
    input  ex_pipe_pkg::fwd_sel_t fwd_a_sel_i,
    input  ex_pipe_pkg::fwd_sel_t fwd_b_sel_i,
    input  logic                  stall_m_i,
    input  logic                  flush_e_i,
    output logic                  ex_stall_req_o,
    // To fetch
    output logic                  redirect_o,
    output rv_isa_pkg::addr_t     redirect_target_o,
    // To memory stage
    output ex_pipe_pkg::ex_mem_t  ex_mem_o
);
    import rv_isa_pkg::*;
    import ex_pipe_pkg::*;

    operands_t operands;
    word_t     alu_result;
    logic      alu_zero;
    word_t     mul_result;
    logic      mul_done;

    // ========================================================================
    // Input side
    // ========================================================================
    operand_select u_operand_select (
        .id_ex_i      (id_ex_i),
        .ex_mem_fwd_i (ex_mem_fwd_i),
        .wb_data_i    (wb_data_i),
        .fwd_a_sel_i  (fwd_a_sel_i),
        .fwd_b_sel_i  (fwd_b_sel_i),
        .operands_o   (operands)
    );

    // ========================================================================
    // Processing
    // ========================================================================
    int_alu u_int_alu (
        .alu_op_i    (id_ex_i.ctrl.alu_op),
        .operand_a_i (operands.alu_a),
        .operand_b_i (operands.alu_b),
        .result_o    (alu_result),
        .zero_o      (alu_zero)
    );

    branch_resolve u_branch_resolve (
        .id_ex_i           (id_ex_i),
        .alu_result_i      (alu_result),
        .alu_zero_i        (alu_zero),
        .redirect_o        (redirect_o),
        .redirect_target_o (redirect_target_o)
    );

    // Multiplier takes the forwarded registers, not the ALU inputs
    mul_iterative u_mul_iterative (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .start_i     (id_ex_i.ctrl.mult_en),
        .operand_a_i (operands.fwd_a),
        .operand_b_i (operands.fwd_b),
        .funct3_i    (id_ex_i.ctrl.funct3),
        .hold_i      (stall_m_i),
        .result_o    (mul_result),
        .done_o      (mul_done)
    );

    // Output side
    ex_result_stage u_ex_result_stage (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .id_ex_i      (id_ex_i),
        .fwd_b_i      (operands.fwd_b),
        .alu_result_i (alu_result),
        .mul_result_i (mul_result),
        .mul_done_i   (mul_done),
        .stall_m_i    (stall_m_i),
        .flush_e_i    (flush_e_i),
        .stall_req_o  (ex_stall_req_o),
        .ex_mem_o     (ex_mem_o)
    );

endmodule

/* hw/ex_result_stage.sv */
// Execute result select and EX/MEM pipeline register
// Muxes ALU, product or link address, raises the multiply stall request

module ex_result_stage (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  ex_pipe_pkg::id_ex_t  id_ex_i,
    input  rv_isa_pkg::word_t    fwd_b_i,
    input  rv_isa_pkg::word_t    alu_result_i,
    input  rv_isa_pkg::word_t    mul_result_i,
    input  logic                 mul_done_i,
    input  logic                 stall_m_i,
    input  logic                 flush_e_i,
    output logic                 stall_req_o,
    output ex_pipe_pkg::ex_mem_t ex_mem_o
);
    import rv_isa_pkg::*;
    import ex_pipe_pkg::*;

    word_t                 result;
    ctrl_t                 ctrl_d;
    ctrl_t                 ctrl_q;
    word_t                 result_q;
    word_t                 store_q;
    logic [REG_ADDR_W-1:0] rd_q;

    // Jumps write the link address pc + 4
    always_comb begin
        if (id_ex_i.ctrl.mult_en)      result = mul_result_i;
        else if (id_ex_i.ctrl.is_jump) result = id_ex_i.pc + word_t'(INSN_BYTES);
        else                           result = alu_result_i;
    end

    // Low again in the cycle the product is ready
    assign stall_req_o = id_ex_i.ctrl.mult_en && !mul_done_i;

    // Flush, or a multiply still running, sends a bubble to MEM
    always_comb begin
        ctrl_d = id_ex_i.ctrl;
        if (flush_e_i || stall_req_o) begin
            ctrl_d.reg_write_en = 1'b0;
            ctrl_d.mem_read_en  = 1'b0;
            ctrl_d.mem_write_en = 1'b0;
            ctrl_d.mult_en      = 1'b0;
        end
    end

    // ========================================================================
    // EX/MEM register, frozen while MEM stalls
    // ========================================================================
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) ctrl_q <= '0;
        else if (!stall_m_i) ctrl_q <= ctrl_d;
    end

    always_ff @(posedge clk_i) begin
        if (!stall_m_i && !stall_req_o) begin
            result_q <= result;
            store_q  <= fwd_b_i;
            rd_q     <= id_ex_i.rd_addr;
        end
    end

    assign ex_mem_o = '{result: result_q, store_data: store_q, rd_addr: rd_q, ctrl: ctrl_q};

    a_hold_on_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
        stall_m_i |=> $stable(ex_mem_o))
    else $error("ex_result_stage: EX/MEM changed under memory stall");

endmodule

/* hw/mul_iterative.sv */
// Iterative RV32M multiplier
// Shift-add over unsigned magnitudes, one bit per cycle, sign fixed at the end
// Serves MUL, MULH, MULHSU and MULHU

module mul_iterative (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                start_i,
    input  rv_isa_pkg::word_t   operand_a_i,
    input  rv_isa_pkg::word_t   operand_b_i,
    input  rv_isa_pkg::funct3_t funct3_i,
    input  logic                hold_i,
    output rv_isa_pkg::word_t   result_o,
    output logic                done_o
);
    import rv_isa_pkg::*;
    import ex_pipe_pkg::*;

    localparam int unsigned CNT_W = $clog2(MUL_STEPS);

    typedef enum logic [1:0] {MUL_IDLE, MUL_BUSY, MUL_DONE} mul_state_e;

    mul_state_e        state_q;
    logic [CNT_W-1:0]  step_q;
    logic [2*XLEN-1:0] prod_q;
    logic [2*XLEN-1:0] mcand_q;
    logic [2*XLEN-1:0] prod_signed;
    word_t             mplier_q;
    logic              negate_q;
    logic              high_q;
    logic              a_neg;
    logic              b_neg;
    word_t             a_mag;
    word_t             b_mag;

    // MULHU treats both unsigned, MULHSU only rs1 signed
    // MUL low word is the same either way
    always_comb begin
        a_neg = (funct3_i != MUL_HU) && operand_a_i[XLEN-1];
        b_neg = (funct3_i == MUL_LO || funct3_i == MUL_H) && operand_b_i[XLEN-1];
        a_mag = a_neg ? -operand_a_i : operand_a_i;
        b_mag = b_neg ? -operand_b_i : operand_b_i;
    end

    // ========================================================================
    // Sequencer
    // ========================================================================
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= MUL_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                MUL_IDLE: if (start_i) begin
                    state_q <= MUL_BUSY;
                    step_q  <= '0;
                end
                MUL_BUSY: begin
                    if (step_q == CNT_W'(MUL_STEPS - 1)) state_q <= MUL_DONE;
                    step_q <= step_q + 1'b1;
                end
                // Result stays up until the memory stage can take it
                MUL_DONE: if (!hold_i) state_q <= MUL_IDLE;
                default:  state_q <= MUL_IDLE;
            endcase
        end
    end

    // Datapath, one partial product per step
    always_ff @(posedge clk_i) begin
        if (state_q == MUL_IDLE && start_i) begin
            prod_q   <= '0;
            mcand_q  <= {{XLEN{1'b0}}, a_mag};
            mplier_q <= b_mag;
            negate_q <= a_neg ^ b_neg;
            high_q   <= (funct3_i != MUL_LO);
        end else if (state_q == MUL_BUSY) begin
            if (mplier_q[0]) prod_q <= prod_q + mcand_q;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign prod_signed = negate_q ? -prod_q : prod_q;
    assign result_o    = high_q ? prod_signed[2*XLEN-1:XLEN] : prod_signed[XLEN-1:0];
    assign done_o      = (state_q == MUL_DONE);

    // Hazard unit holds ID/EX and the forwarding paths for the whole run
    a_operands_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (state_q == MUL_BUSY) |-> ($stable(operand_a_i) && $stable(operand_b_i)))
    else $error("mul_iterative: operand changed while busy");

endmodule

/* hw/branch_resolve.sv */
// Branch and jump resolution
// Decides taken from the ALU flags and drives the fetch redirect

module branch_resolve (
    input  ex_pipe_pkg::id_ex_t id_ex_i,
    input  rv_isa_pkg::word_t   alu_result_i,
    input  logic                alu_zero_i,
    output logic                redirect_o,
    output rv_isa_pkg::addr_t   redirect_target_o
);
    import rv_isa_pkg::*;

    logic  cond_true;
    logic  is_jalr;
    addr_t pc_rel_target;

    // Decode set SUB for EQ/NE and SLT or SLTU for the rest
    always_comb begin
        case (id_ex_i.ctrl.funct3)
            BR_EQ:   cond_true = alu_zero_i;
            BR_NE:   cond_true = !alu_zero_i;
            BR_LT:   cond_true = alu_result_i[0];
            BR_GE:   cond_true = !alu_result_i[0];
            BR_LTU:  cond_true = alu_result_i[0];
            BR_GEU:  cond_true = !alu_result_i[0];
            default: cond_true = 1'b0;
        endcase
    end

    // JALR is the only jump with a register base
    assign is_jalr       = id_ex_i.ctrl.is_jump && !id_ex_i.ctrl.alu_a_pc;
    assign pc_rel_target = id_ex_i.pc + id_ex_i.immediate;

    assign redirect_o = (id_ex_i.ctrl.is_branch && cond_true) || id_ex_i.ctrl.is_jump;

    // JALR clears bit 0 of rs1 + imm
    assign redirect_target_o = is_jalr ? {alu_result_i[XLEN-1:1], 1'b0} : pc_rel_target;

    // Decode marks an instruction as branch or jump, never both
    always_comb begin
        assert final ((id_ex_i.ctrl.is_branch & id_ex_i.ctrl.is_jump) !== 1'b1)
        else $error("branch_resolve: is_branch and is_jump both set");
    end

endmodule

/* hw/int_alu.sv */
// Single-cycle integer ALU
// Arithmetic, logic, shifts, compares and pass-through ops, plus zero flag

module int_alu (
    input  rv_isa_pkg::alu_op_t alu_op_i,
    input  rv_isa_pkg::word_t   operand_a_i,
    input  rv_isa_pkg::word_t   operand_b_i,
    output rv_isa_pkg::word_t   result_o,
    output logic                zero_o
);
    import rv_isa_pkg::*;

    logic [SHAMT_W-1:0] shamt;
    word_t              sum;
    word_t              diff;
    logic               lt_signed;
    logic               lt_unsigned;

    // Only the low bits of B count for RV32 shifts
    assign shamt = operand_b_i[SHAMT_W-1:0];

    assign sum  = operand_a_i + operand_b_i;
    assign diff = operand_a_i - operand_b_i;

    // Compares feed SLT/SLTU and the branch conditions
    assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
    assign lt_unsigned = operand_a_i < operand_b_i;

    // ========================================================================
    // Operation select
    // ========================================================================
    always_comb begin
        case (alu_op_i)
            ADD:     result_o = sum;
            SUB:     result_o = diff;
            XOR:     result_o = operand_a_i ^ operand_b_i;
            OR:      result_o = operand_a_i | operand_b_i;
            AND:     result_o = operand_a_i & operand_b_i;
            SLL:     result_o = operand_a_i << shamt;
            SRL:     result_o = operand_a_i >> shamt;
            // Arithmetic shift keeps the sign bit
            SRA:     result_o = word_t'($signed(operand_a_i) >>> shamt);
            SLT:     result_o = {{(XLEN-1){1'b0}}, lt_signed};
            SLTU:    result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            // U-type immediate, low 12 bits forced clear
            LUI:     result_o = {operand_b_i[XLEN-1:12], 12'b0};
            COPY_B:  result_o = operand_b_i;
            default: result_o = '0;
        endcase
    end

    // EQ/NE branches look at this after a SUB
    assign zero_o = (result_o == '0);

endmodule

/* hw/operand_select.sv */
// Execute stage operand selection
// Forwards rs1/rs2 from register, MEM or WB, then builds the ALU inputs

module operand_select (
    input  ex_pipe_pkg::id_ex_t    id_ex_i,
    input  ex_pipe_pkg::ex_mem_t   ex_mem_fwd_i,
    input  rv_isa_pkg::word_t      wb_data_i,
    input  ex_pipe_pkg::fwd_sel_t  fwd_a_sel_i,
    input  ex_pipe_pkg::fwd_sel_t  fwd_b_sel_i,
    output ex_pipe_pkg::operands_t operands_o
);
    import rv_isa_pkg::*;
    import ex_pipe_pkg::*;

    // Same three-way pick for both source registers
    function automatic word_t fwd_pick(
        input fwd_sel_t sel,
        input word_t    reg_val,
        input word_t    mem_val,
        input word_t    wb_val
    );
        case (sel)
            FWD_MEM: fwd_pick = mem_val;
            FWD_WB:  fwd_pick = wb_val;
            default: fwd_pick = reg_val;
        endcase
    endfunction

    always_comb begin
        operands_o.fwd_a = fwd_pick(fwd_a_sel_i, id_ex_i.rs1_data,
                                    ex_mem_fwd_i.result, wb_data_i);
        operands_o.fwd_b = fwd_pick(fwd_b_sel_i, id_ex_i.rs2_data,
                                    ex_mem_fwd_i.result, wb_data_i);

        // AUIPC and JAL add to the PC, immediates replace rs2
        operands_o.alu_a = id_ex_i.ctrl.alu_a_pc  ? id_ex_i.pc        : operands_o.fwd_a;
        operands_o.alu_b = id_ex_i.ctrl.alu_b_imm ? id_ex_i.immediate : operands_o.fwd_b;
    end

    // Hazard unit never drives the unused encoding
    always_comb begin
        assert final ($isunknown(fwd_a_sel_i) || fwd_a_sel_i inside {FWD_REG, FWD_MEM, FWD_WB})
        else $error("operand_select: undefined forward A select %b", fwd_a_sel_i);
        assert final ($isunknown(fwd_b_sel_i) || fwd_b_sel_i inside {FWD_REG, FWD_MEM, FWD_WB})
        else $error("operand_select: undefined forward B select %b", fwd_b_sel_i);
    end

endmodule

/* hw/ex_pipe_pkg.sv */
// Execute stage pipeline types
// Stage register layouts, forwarding selects and multiplier timing

package ex_pipe_pkg;

    localparam int unsigned REG_ADDR_W = 5;
    // One shift-add step per multiplier bit
    localparam int unsigned MUL_STEPS  = rv_isa_pkg::XLEN;

    // Forwarding source, driven by the hazard unit
    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_MEM = 2'b01,
        FWD_WB  = 2'b10
    } fwd_sel_t;

    // ========================================================================
    // Stage register layouts
    // ========================================================================
    typedef struct packed {
        rv_isa_pkg::alu_op_t alu_op;
        rv_isa_pkg::funct3_t funct3;
        logic                alu_a_pc;
        logic                alu_b_imm;
        logic                is_branch;
        logic                is_jump;
        logic                mult_en;
        logic                reg_write_en;
        logic                mem_read_en;
        logic                mem_write_en;
    } ctrl_t;

    typedef struct packed {
        rv_isa_pkg::addr_t     pc;
        rv_isa_pkg::word_t     rs1_data;
        rv_isa_pkg::word_t     rs2_data;
        rv_isa_pkg::word_t     immediate;
        logic [REG_ADDR_W-1:0] rd_addr;
        ctrl_t                 ctrl;
    } id_ex_t;

    typedef struct packed {
        rv_isa_pkg::word_t     result;
        rv_isa_pkg::word_t     store_data;
        logic [REG_ADDR_W-1:0] rd_addr;
        ctrl_t                 ctrl;
    } ex_mem_t;

    // Forwarded register values and the ALU inputs built from them
    typedef struct packed {
        rv_isa_pkg::word_t fwd_a;
        rv_isa_pkg::word_t fwd_b;
        rv_isa_pkg::word_t alu_a;
        rv_isa_pkg::word_t alu_b;
    } operands_t;

endpackage

/* hw/rv_isa_pkg.sv */
// RV32 ISA definitions used across the execute stage
// Word widths, ALU operation encoding and funct3 codes

package rv_isa_pkg;

    // ========================================================================
    // Widths
    // ========================================================================
    localparam int unsigned XLEN       = 32;
    localparam int unsigned SHAMT_W    = 5;
    // Fixed 32-bit encodings, no compressed set
    localparam int unsigned INSN_BYTES = 4;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [XLEN-1:0] addr_t;
    typedef logic [2:0]      funct3_t;

    // ALU operation, picked by decode
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        XOR    = 4'd2,
        OR     = 4'd3,
        AND    = 4'd4,
        SLL    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        SLT    = 4'd8,
        SLTU   = 4'd9,
        LUI    = 4'd10,
        COPY_B = 4'd11
    } alu_op_t;

    // ========================================================================
    // funct3 codes
    // ========================================================================
    localparam funct3_t BR_EQ   = 3'b000;
    localparam funct3_t BR_NE   = 3'b001;
    localparam funct3_t BR_LT   = 3'b100;
    localparam funct3_t BR_GE   = 3'b101;
    localparam funct3_t BR_LTU  = 3'b110;
    localparam funct3_t BR_GEU  = 3'b111;

    // RV32M multiply group
    localparam funct3_t MUL_LO  = 3'b000;
    localparam funct3_t MUL_H   = 3'b001;
    localparam funct3_t MUL_HSU = 3'b010;
    localparam funct3_t MUL_HU  = 3'b011;

endpackage
